// ==== Makefile ====
TOP := fetch_frontend_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// ==== design/branch_predecode.sv ====
`default_nettype none

module branch_predecode import fetch_pkg::*; (
    fetch_item_if.consumer   item,

    output logic            bp_error_o,
    output logic            bp_advance_o,
    output logic [XLEN-1:0] jump_target_o
);

    logic [OP_W-1:0] opcode;
    logic            is_branch;
    logic            is_direct;
    logic [XLEN-1:0] seq_pc;
    logic [XLEN-1:0] offset;

    assign opcode = item.inst.fmt_2ri16.opcode;

    always_comb begin
        is_branch = 1'b0;
        is_direct = 1'b0;
        case (opcode)
            OP_JIRL: is_branch = 1'b1;
            OP_B,
            OP_BL: begin
                is_branch = 1'b1;
                is_direct = 1'b1;      // unconditional, target known now.
            end
            OP_BEQ,
            OP_BNE,
            OP_BLT,
            OP_BGE,
            OP_BLTU,
            OP_BGEU: is_branch = 1'b1;
            default: ;
        endcase
    end

    assign seq_pc = item.pc + XLEN'(4);

    // btb hit on something that cannot jump.
    assign bp_error_o = item.fire & ~is_branch & item.next_predict
                      & (item.next_pc != seq_pc);

    assign bp_advance_o = item.fire & is_direct;

    // 26-bit word offset, hi part sits in the low bits.
    assign offset = {{4{item.inst.fmt_i26.offs_hi10[9]}},
                     item.inst.fmt_i26.offs_hi10,
                     item.inst.fmt_i26.offs_lo16,
                     2'b00};

    assign jump_target_o = item.pc + offset;

endmodule

`default_nettype wire

// ==== design/fetch_frontend.sv ====
`default_nettype none

module fetch_frontend import fetch_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,

    input  wire logic            valid_i,
    input  wire logic [XLEN-1:0] pc_i,
    input  wire logic [XLEN-1:0] next_pc_i,
    input  wire logic            next_predict_i,
    input  wire logic            stall_i,
    input  wire logic            flush_i,
    output      logic            stall_o,

    output      logic            wb_cyc_o,
    output      logic            wb_stb_o,
    output      logic [XLEN-1:0] wb_adr_o,
    input  wire logic [XLEN-1:0] wb_dat_i,
    input  wire logic            wb_ack_i,

    output      logic            dec_valid_o,
    output      logic [XLEN-1:0] dec_pc_o,
    output      logic [XLEN-1:0] dec_inst_o,
    output      logic [XLEN-1:0] dec_next_pc_o,
    output      logic            dec_next_predict_o,

    output      logic            redirect_valid_o,
    output      logic [XLEN-1:0] redirect_pc_o,
    output      logic            redirect_predict_o,

    output      logic            btb_inval_o,
    output      logic [XLEN-1:0] btb_inval_pc_o
);

    logic            bp_error;
    logic            bp_advance;
    logic [XLEN-1:0] jump_target;
    logic            ret_hit;
    logic [XLEN-1:0] ret_target;

    fetch_item_if item_bus ();

    fetch_wb_stage u_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_i        (valid_i),
        .pc_i           (pc_i),
        .next_pc_i      (next_pc_i),
        .next_predict_i (next_predict_i),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .stall_o        (stall_o),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_adr_o       (wb_adr_o),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_i       (wb_ack_i),
        .item           (item_bus.stage)
    );

    branch_predecode u_predecode (
        .item          (item_bus.consumer),
        .bp_error_o    (bp_error),
        .bp_advance_o  (bp_advance),
        .jump_target_o (jump_target)
    );

    return_stack u_ras (
        .clk          (clk),
        .rst_n        (rst_n),
        .item         (item_bus.consumer),
        .ret_hit_o    (ret_hit),
        .ret_target_o (ret_target)
    );

    redirect_select u_select (
        .item               (item_bus.consumer),
        .bp_error_i         (bp_error),
        .bp_advance_i       (bp_advance),
        .jump_target_i      (jump_target),
        .ret_hit_i          (ret_hit),
        .ret_target_i       (ret_target),
        .redirect_valid_o   (redirect_valid_o),
        .redirect_pc_o      (redirect_pc_o),
        .redirect_predict_o (redirect_predict_o),
        .next_pc_o          (dec_next_pc_o),
        .next_predict_o     (dec_next_predict_o)
    );

    assign dec_valid_o = item_bus.fire;
    assign dec_pc_o    = item_bus.pc;
    assign dec_inst_o  = item_bus.inst;   // straight from the bus.

    // stale btb entry for this pc.
    assign btb_inval_o    = bp_error;
    assign btb_inval_pc_o = item_bus.pc;

endmodule

`default_nettype wire

// ==== design/fetch_item_if.sv ====
`default_nettype none

interface fetch_item_if import fetch_pkg::*; ();

    logic            fire;         // item leaves the stage.
    logic [XLEN-1:0] pc;
    inst_word_u      inst;
    logic [XLEN-1:0] next_pc;      // upstream prediction.
    logic            next_predict;

    modport stage (
        output fire,
        output pc,
        output inst,
        output next_pc,
        output next_predict
    );

    modport consumer (
        input fire,
        input pc,
        input inst,
        input next_pc,
        input next_predict
    );

endinterface

`default_nettype wire

// ==== design/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam int XLEN = 32;
    localparam int OP_W = 6;

    // major opcodes of the branch group.
    localparam logic [OP_W-1:0] OP_JIRL = 6'b010011;
    localparam logic [OP_W-1:0] OP_B    = 6'b010100;
    localparam logic [OP_W-1:0] OP_BL   = 6'b010101;
    localparam logic [OP_W-1:0] OP_BEQ  = 6'b010110;
    localparam logic [OP_W-1:0] OP_BNE  = 6'b010111;
    localparam logic [OP_W-1:0] OP_BLT  = 6'b011000;
    localparam logic [OP_W-1:0] OP_BGE  = 6'b011001;
    localparam logic [OP_W-1:0] OP_BLTU = 6'b011010;
    localparam logic [OP_W-1:0] OP_BGEU = 6'b011011;

    // jirl r0, r1, 0
    localparam logic [XLEN-1:0] INST_RETURN = {OP_JIRL, 16'h0000, 5'd1, 5'd0};

    localparam int RAS_DEPTH = 8;
    localparam int RAS_PTR_W = 3;

    // two readings of the same instruction word.
    typedef union packed {
        struct packed {
            logic [OP_W-1:0] opcode;
            logic [15:0]     offs16;
            logic [4:0]      rj;
            logic [4:0]      rd;
        } fmt_2ri16;
        struct packed {
            logic [OP_W-1:0] opcode;
            logic [15:0]     offs_lo16;
            logic [9:0]      offs_hi10;
        } fmt_i26;
    } inst_word_u;

endpackage

`default_nettype wire

// ==== design/fetch_wb_stage.sv ====
`default_nettype none

module fetch_wb_stage import fetch_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,

    input  wire logic            valid_i,
    input  wire logic [XLEN-1:0] pc_i,
    input  wire logic [XLEN-1:0] next_pc_i,
    input  wire logic            next_predict_i,

    input  wire logic            stall_i,
    input  wire logic            flush_i,
    output      logic            stall_o,

    output      logic            wb_cyc_o,
    output      logic            wb_stb_o,
    output      logic [XLEN-1:0] wb_adr_o,
    input  wire logic [XLEN-1:0] wb_dat_i,
    input  wire logic            wb_ack_i,

    fetch_item_if.stage          item
);

    logic            valid_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] next_pc_q;
    logic            next_predict_q;
    logic            load;
    logic            req;

    // held item still waiting for its word.
    assign stall_o = stall_i | (valid_q & ~wb_ack_i);

    assign load = ~stall_o & valid_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;                // drop held item.
        end else if (!stall_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            pc_q           <= pc_i;
            next_pc_q      <= next_pc_i;
            next_predict_q <= next_predict_i;
        end
    end

    // one classic read per held item, read only.
    assign req      = valid_q & ~flush_i;
    assign wb_cyc_o = req;
    assign wb_stb_o = req;
    assign wb_adr_o = pc_q;

    // ack only counts when decode can take the word.
    assign item.fire         = req & wb_ack_i & ~stall_i;
    assign item.pc           = pc_q;
    assign item.inst         = wb_dat_i;
    assign item.next_pc      = next_pc_q;
    assign item.next_predict = next_predict_q;

endmodule

`default_nettype wire

// ==== design/redirect_select.sv ====
`default_nettype none

module redirect_select import fetch_pkg::*; (
    fetch_item_if.consumer   item,

    input  wire logic            bp_error_i,
    input  wire logic            bp_advance_i,
    input  wire logic [XLEN-1:0] jump_target_i,
    input  wire logic            ret_hit_i,
    input  wire logic [XLEN-1:0] ret_target_i,

    output      logic            redirect_valid_o,
    output      logic [XLEN-1:0] redirect_pc_o,
    output      logic            redirect_predict_o,
    output      logic [XLEN-1:0] next_pc_o,
    output      logic            next_predict_o
);

    always_comb begin
        redirect_valid_o   = 1'b1;
        redirect_pc_o      = '0;
        redirect_predict_o = 1'b0;
        if (bp_error_i) begin
            redirect_pc_o = item.pc + XLEN'(4);    // fall through.
        end else if (bp_advance_i) begin
            redirect_pc_o = jump_target_i;
        end else if (ret_hit_i) begin
            redirect_pc_o      = ret_target_i;
            redirect_predict_o = 1'b1;           // still a guess.
        end else begin
            redirect_valid_o = 1'b0;
        end
    end

    // decode sees the corrected next pc.
    assign next_pc_o      = redirect_valid_o ? redirect_pc_o : item.next_pc;
    assign next_predict_o = redirect_valid_o ? redirect_predict_o : item.next_predict;

endmodule

`default_nettype wire

// ==== design/return_stack.sv ====
`default_nettype none

module return_stack import fetch_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,

    fetch_item_if.consumer   item,

    output logic            ret_hit_o,
    output logic [XLEN-1:0] ret_target_o
);

    localparam int CNT_W = RAS_PTR_W + 1;

    logic [XLEN-1:0]      stack_q [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] top_q;
    logic [RAS_PTR_W-1:0] push_ptr;
    logic [CNT_W-1:0]     fill_q;
    logic                 is_call;
    logic                 is_return;
    logic                 push;
    logic                 pop;

    assign is_call   = item.inst.fmt_i26.opcode == OP_BL;
    assign is_return = item.inst == INST_RETURN;

    assign push = item.fire & is_call;
    assign pop  = item.fire & is_return & (fill_q != '0);

    assign push_ptr = top_q + 1'b1;   // wraps, oldest entry lost.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            top_q  <= '0;
            fill_q <= '0;
        end else if (push) begin
            top_q <= push_ptr;
            if (fill_q != CNT_W'(RAS_DEPTH)) begin
                fill_q <= fill_q + 1'b1;
            end
        end else if (pop) begin
            top_q  <= top_q - 1'b1;
            fill_q <= fill_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            stack_q[push_ptr] <= item.pc + XLEN'(4);   // link address.
        end
    end

    assign ret_hit_o    = pop;
    assign ret_target_o = stack_q[top_q];

endmodule

`default_nettype wire

// ==== filelist.f ====
design/fetch_pkg.sv
design/fetch_item_if.sv
design/fetch_wb_stage.sv
design/branch_predecode.sv
design/return_stack.sv
design/redirect_select.sv
design/fetch_frontend.sv
verification/tb_clock_gen.sv
verification/fetch_frontend_props.sv
verification/fetch_frontend_tb.sv

// ==== verification/fetch_frontend_props.sv ====
`default_nettype none

module fetch_frontend_props import fetch_pkg::*; (
    input wire logic            clk,
    input wire logic            rst_n,
    input wire logic            flush_i,
    input wire logic            wb_cyc_i,
    input wire logic            wb_stb_i,
    input wire logic [XLEN-1:0] wb_adr_i,
    input wire logic            wb_ack_i,
    input wire logic            stage_stall_i
);

    int unsigned fail_cnt = 0;

    // cycle stays open until the slave answers, unless flushed.
    cyc_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc_i && wb_stb_i && !wb_ack_i |=> (wb_cyc_i && wb_stb_i) || flush_i)
        else begin $error("cycle dropped before ack"); fail_cnt++; end

    // address held until the slave answers.
    adr_held: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb_i && !wb_ack_i |=> $stable(wb_adr_i))
        else begin $error("address moved before ack"); fail_cnt++; end

    stall_while_waiting: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb_i && !wb_ack_i |-> stage_stall_i)
        else begin $error("upstream not stalled while waiting"); fail_cnt++; end

endmodule

`default_nettype wire

// ==== verification/fetch_frontend_tb.sv ====
`default_nettype none

module fetch_frontend_tb import fetch_pkg::*; ();

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] next_pc;
        logic            predict;
        logic [XLEN-1:0] inst;
        logic [1:0]      stall_cyc;
        logic            flush;
        logic            exp_redirect;
    } entry_t;

    logic            clk;
    logic            rst_n;
    logic            valid_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] next_pc_i;
    logic            next_predict_i;
    logic            stall_i;
    logic            flush_i;
    logic            stall_o;
    logic            wb_cyc_o;
    logic            wb_stb_o;
    logic [XLEN-1:0] wb_adr_o;
    logic [XLEN-1:0] wb_dat_i = '0;
    logic            wb_ack_i = 1'b0;
    logic            dec_valid_o;
    logic [XLEN-1:0] dec_pc_o;
    logic [XLEN-1:0] dec_inst_o;
    logic [XLEN-1:0] dec_next_pc_o;
    logic            dec_next_predict_o;
    logic            redirect_valid_o;
    logic [XLEN-1:0] redirect_pc_o;
    logic            redirect_predict_o;
    logic            btb_inval_o;
    logic [XLEN-1:0] btb_inval_pc_o;

    logic [XLEN-1:0] mem [256];
    entry_t          tbl [$];
    int              pending [$];     // indices still to be delivered.
    logic [XLEN-1:0] ras_model [$];
    int              seed = 32'h3b32;
    int              wait_cnt = 0;
    int              delivered = 0;
    int              expected = 0;
    logic            table_ready = 1'b0;

    tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    fetch_frontend uut (.*);

    bind fetch_wb_stage fetch_frontend_props u_props (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .wb_cyc_i      (wb_cyc_o),
        .wb_stb_i      (wb_stb_o),
        .wb_adr_i      (wb_adr_o),
        .wb_ack_i      (wb_ack_i),
        .stage_stall_i (stall_o)
    );

    function automatic logic [XLEN-1:0] encode_jump(input logic [OP_W-1:0] op,
                                                    input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [XLEN-1:0] encode_reg_imm(input logic [OP_W-1:0] op,
                                                       input logic [15:0] offs,
                                                       input logic [4:0] rj,
                                                       input logic [4:0] rd);
        return {op, offs, rj, rd};
    endfunction

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_inst(input inst_word_u got, input inst_word_u exp);
        if (got !== exp) begin
            $display("FAILED at %0t: dec_inst_o is %h, expected %h", $time, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic add_entry(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] npc,
                             input logic pred, input logic [XLEN-1:0] inst,
                             input logic [1:0] stall, input logic flush, input logic redir);
        tbl.push_back('{pc, npc, pred, inst, stall, flush, redir});
    endtask

    // pc, next_pc, predict, inst, stall cycles, flush, redirect expected.
    task automatic build_table();
        add_entry(32'h1000, 32'h1004, 1'b0, 32'h0010_1a85, 2'd0, 1'b0, 1'b0);
        add_entry(32'h1004, 32'h1008, 1'b1, 32'h0280_1085, 2'd1, 1'b0, 1'b0);
        add_entry(32'h1008, 32'h2000, 1'b0, 32'h2880_0ca5, 2'd0, 1'b0, 1'b0);
        add_entry(32'h100c, 32'h1200, 1'b1, 32'h0010_1a85, 2'd0, 1'b0, 1'b1);
        add_entry(32'h1010, 32'h1014, 1'b0, encode_jump(OP_B, 26'h000_0010), 2'd2, 1'b0, 1'b1);
        add_entry(32'h1014, 32'h0ff4, 1'b1, encode_jump(OP_B, 26'h3ff_fff8), 2'd0, 1'b0, 1'b1);
        add_entry(32'h1018, 32'h101c, 1'b0, encode_jump(OP_BL, 26'h000_0100), 2'd2, 1'b0, 1'b1);
        add_entry(32'h101c, 32'h1020, 1'b0, INST_RETURN, 2'd1, 1'b0, 1'b1);
        add_entry(32'h1020, 32'h1024, 1'b0, encode_jump(OP_BL, 26'h3ff_fffc), 2'd0, 1'b0, 1'b1);
        add_entry(32'h1024, 32'h1028, 1'b0, encode_jump(OP_BL, 26'h010_0020), 2'd3, 1'b0, 1'b1);
        add_entry(32'h1028, 32'h102c, 1'b0, 32'h0010_1a85, 2'd2, 1'b1, 1'b0);
        add_entry(32'h102c, 32'h1030, 1'b0, INST_RETURN, 2'd0, 1'b0, 1'b1);
        add_entry(32'h1030, 32'h1034, 1'b0, INST_RETURN, 2'd1, 1'b0, 1'b1);
        add_entry(32'h1034, 32'h5000, 1'b1, INST_RETURN, 2'd0, 1'b0, 1'b0);
        add_entry(32'h1038, 32'h1100, 1'b1, encode_reg_imm(OP_BEQ, 16'h0003, 5'd4, 5'd5),
                  2'd0, 1'b0, 1'b0);
        add_entry(32'h103c, 32'h3000, 1'b1, encode_reg_imm(OP_JIRL, 16'h0001, 5'd5, 5'd1),
                  2'd2, 1'b0, 1'b0);
        add_entry(32'h1040, 32'h1044, 1'b0, 32'h2880_0ca5, 2'd3, 1'b0, 1'b0);
        add_entry(32'h1044, 32'h1048, 1'b0, INST_RETURN, 2'd0, 1'b1, 1'b0);
        add_entry(32'h1048, 32'h104c, 1'b0, encode_jump(OP_BL, 26'h000_0040), 2'd3, 1'b0, 1'b1);
        add_entry(32'h104c, 32'h1100, 1'b1, 32'h0280_1085, 2'd0, 1'b0, 1'b1);
        add_entry(32'h1050, 32'h1054, 1'b0, INST_RETURN, 2'd1, 1'b0, 1'b1);
    endtask

    task automatic load_memory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h0040_0000 | (i << 2);    // non-branch filler.
        end
        foreach (tbl[k]) begin
            mem[tbl[k].pc[9:2]] = tbl[k].inst;
        end
    endtask

    // slave keeps ack and data until the word is taken or stb falls.
    always @(posedge clk) begin
        if (!rst_n) begin
            wb_ack_i <= 1'b0;
        end else if (!(wb_cyc_o && wb_stb_o) || (wb_ack_i && !stall_i)) begin
            wb_ack_i <= 1'b0;
            wait_cnt <= $random(seed) & 3;
        end else if (!wb_ack_i) begin
            if (wait_cnt == 0) begin
                wb_ack_i <= 1'b1;
                wb_dat_i <= mem[wb_adr_o[9:2]];
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    task automatic send_item(input int k);
        entry_t e;
        e = tbl[k];
        if (!e.flush) begin
            pending.push_back(k);
            expected++;
        end
        @(posedge clk);
        valid_i        <= 1'b1;
        pc_i           <= e.pc;
        next_pc_i      <= e.next_pc;
        next_predict_i <= e.predict;
        @(negedge clk);
        while (stall_o) @(negedge clk);
        @(posedge clk);                      // item loads here.
        valid_i <= 1'b0;
        stall_i <= (e.stall_cyc != 2'd0) || e.flush;
        repeat (e.stall_cyc) @(posedge clk);
        if (e.flush) begin
            flush_i <= 1'b1;
            @(posedge clk);
            flush_i <= 1'b0;
        end
        stall_i <= 1'b0;
    endtask

    task automatic check_delivery();
        entry_t          e;
        logic [XLEN-1:0] seq_pc;
        logic [XLEN-1:0] target;
        logic [XLEN-1:0] exp_pc;
        logic [25:0]     offs;
        logic [OP_W-1:0] op;
        logic            is_branch;
        logic            is_return;
        logic            bad_predict;
        logic            exp_redir;
        logic            exp_pred;
        e           = tbl[pending.pop_front()];
        seq_pc      = e.pc + 32'd4;
        op          = e.inst[31:26];
        offs        = {e.inst[9:0], e.inst[25:10]};
        target      = e.pc + {{4{offs[25]}}, offs, 2'b00};
        is_branch   = (op >= OP_JIRL) && (op <= OP_BGEU);
        is_return   = (op == OP_JIRL) && (e.inst[25:10] == 16'h0000)
                    && (e.inst[9:5] == 5'd1) && (e.inst[4:0] == 5'd0);
        bad_predict = !is_branch && e.predict && (e.next_pc != seq_pc);
        exp_redir   = 1'b1;
        exp_pred    = 1'b0;
        exp_pc      = '0;
        if (bad_predict) begin
            exp_pc = seq_pc;
        end else if (op == OP_B || op == OP_BL) begin
            exp_pc = target;
        end else if (is_return && ras_model.size() != 0) begin
            exp_pc   = ras_model[$];
            exp_pred = 1'b1;                 // re-predicted from the stack.
        end else begin
            exp_redir = 1'b0;
        end
        check_addr("dec_pc_o", dec_pc_o, e.pc);
        check_inst(dec_inst_o, e.inst);
        check_flag("redirect_valid_o", redirect_valid_o, e.exp_redirect);
        if (exp_redir) begin
            check_addr("redirect_pc_o", redirect_pc_o, exp_pc);
            check_flag("redirect_predict_o", redirect_predict_o, exp_pred);
        end
        check_addr("dec_next_pc_o", dec_next_pc_o, exp_redir ? exp_pc : e.next_pc);
        check_flag("dec_next_predict_o", dec_next_predict_o, exp_redir ? exp_pred : e.predict);
        check_flag("btb_inval_o", btb_inval_o, bad_predict);
        if (bad_predict) begin
            check_addr("btb_inval_pc_o", btb_inval_pc_o, e.pc);
        end
        if (op == OP_BL) begin
            if (ras_model.size() == RAS_DEPTH) begin
                void'(ras_model.pop_front());
            end
            ras_model.push_back(seq_pc);
        end else if (is_return && ras_model.size() != 0) begin
            void'(ras_model.pop_back());
        end
    endtask

    // outputs are steady at the falling edge.
    always @(negedge clk) begin
        if (rst_n) begin
            if (uut.u_stage.u_props.fail_cnt != 0) begin
                $display("a Wishbone or stall assertion failed before %0t", $time);
                stop_with_failure();
            end else if (dec_valid_o) begin
                delivered++;
                if (pending.size() == 0) begin
                    $display("an item was delivered at %0t with nothing outstanding", $time);
                    stop_with_failure();
                end else begin
                    check_delivery();
                end
            end else begin
                check_flag("redirect_valid_o while idle", redirect_valid_o, 1'b0);
                check_flag("btb_inval_o while idle", btb_inval_o, 1'b0);
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (tbl.size() * 10 + 20) @(posedge clk);
        $display("timeout: %0d items still outstanding at %0t", pending.size(), $time);
        stop_with_failure();
    end

    initial begin
        valid_i        = 1'b0;
        pc_i           = '0;
        next_pc_i      = '0;
        next_predict_i = 1'b0;
        stall_i        = 1'b0;
        flush_i        = 1'b0;
        build_table();
        load_memory();
        table_ready = 1'b1;
        while (!rst_n) @(posedge clk);
        foreach (tbl[k]) begin
            send_item(k);
        end
        while (pending.size() != 0) @(negedge clk);
        repeat (6) @(negedge clk);
        if (delivered != expected || uut.u_stage.u_props.fail_cnt != 0) begin
            $display("%0d of %0d items delivered, %0d assertion failures", delivered,
                     expected, uut.u_stage.u_props.fail_cnt);
            stop_with_failure();
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;      // released on an edge.
    end

endmodule

`default_nettype wire
